// ==== source/boardPkg.sv ====
`default_nettype none

package boardPkg;

	// Rows and columns of the square grid.
	localparam int gridSize = 5;

	typedef struct packed {
		logic hit;
		logic [2:0] shipId;
	} cellT;

	// Row-major, cell (r, c) sits at index r * gridSize + c.
	typedef cellT [gridSize*gridSize-1:0] boardT;

	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} shotCmdT;

	typedef enum logic [1:0] {
		outMiss,
		outHit,
		outSunk,
		outRepeat
	} outcomeT;

	typedef struct packed {
		outcomeT outcome;
		logic [2:0] shipId;
		logic fleetSunk;
	} shotRspT;

endpackage

`default_nettype wire

// ==== source/fleetPkg.sv ====
`default_nettype none

package fleetPkg;

	// Ship k is k cells long, so this is also the longest ship.
	localparam int maxShips = 5;

	// Attempt budget for one whole placement.
	localparam int maxAttempts = 255;

	// Galois feedback mask of the 8-bit placement LFSR.
	localparam logic [7:0] lfsrTaps = 8'hB8;

	typedef struct packed {
		logic [7:0] seed;
		logic [2:0] shipCount;
	} placeCmdT;

	typedef struct packed {
		logic ok;
		logic [7:0] attempts;
	} placeRspT;

endpackage

`default_nettype wire

// ==== source/reqAckTarget.sv ====
`timescale 1ns/10ps
`default_nettype none

module reqAckTarget #(
	parameter type payloadT = logic,
	parameter type resultT = logic
) (
	input logic clk,
	input logic rstN,
	input logic req,
	input payloadT payload,
	input logic done,
	input resultT result,
	output logic ack,
	output logic start,
	output payloadT cmd,
	output resultT rsp
);

	typedef enum logic [1:0] {
		stIdle,
		stBusy,
		stAck
	} stateT;

	stateT state;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			start <= 1'b0;
			ack <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				stIdle: begin
					if (req) begin
						state <= stBusy;
						start <= 1'b1;
					end
				end
				stBusy: begin
					if (done) begin
						state <= stAck;
						ack <= 1'b1;
					end
				end
				stAck: begin
					// Ack stays up until the host lets go of req.
					if (!req) begin
						state <= stIdle;
						ack <= 1'b0;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == stIdle && req) begin
			cmd <= payload;
		end
		if (state == stBusy && done) begin
			rsp <= result;
		end
	end

endmodule

`default_nettype wire

// ==== source/shipPlacer.sv ====
`timescale 1ns/10ps
`default_nettype none

module shipPlacer (
	input logic clk,
	input logic rstN,
	input logic start,
	input fleetPkg::placeCmdT cmd,
	output logic done,
	output fleetPkg::placeRspT rsp,
	output logic loadBoard,
	output boardPkg::boardT newBoard
);

	import boardPkg::*;
	import fleetPkg::*;

	typedef enum logic [1:0] {
		psIdle,
		psClear,
		psTry
	} stateT;

	stateT state;
	logic [7:0] lfsr;
	logic [7:0] lfsrNext;
	logic [2:0] curShip;
	logic [7:0] attempts;
	logic [7:0] attemptsNext;
	logic [2:0] rowIdx;
	logic [2:0] colSpan;
	logic [2:0] colIdx;
	logic [4:0] baseIdx;
	logic fits;
	logic lastPlaced;
	logic atLimit;
	boardT boardNext;

	// One placement attempt for the current ship.
	always_comb begin
		rowIdx = 3'(lfsr[2:0] % 3'(gridSize));
		colSpan = 3'(gridSize + 1) - curShip;
		colIdx = lfsr[5:3] % colSpan;
		baseIdx = 5'(rowIdx) * 5'(gridSize) + 5'(colIdx);
		fits = 1'b1;
		for (int i = 0; i < maxShips; i++) begin
			if (3'(i) < curShip && newBoard[baseIdx + 5'(i)].shipId != 3'd0) begin
				fits = 1'b0;
			end
		end
		boardNext = newBoard;
		if (fits) begin
			for (int i = 0; i < maxShips; i++) begin
				if (3'(i) < curShip) begin
					boardNext[baseIdx + 5'(i)].shipId = curShip;
				end
			end
		end
		lfsrNext = {1'b0, lfsr[7:1]} ^ (lfsr[0] ? lfsrTaps : 8'h00);
		attemptsNext = attempts + 8'd1;
		lastPlaced = fits && curShip == 3'd1;
		atLimit = attemptsNext == 8'(maxAttempts);
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= psIdle;
			done <= 1'b0;
			loadBoard <= 1'b0;
		end else begin
			done <= 1'b0;
			loadBoard <= 1'b0;
			case (state)
				psIdle: begin
					if (start) begin
						state <= psClear;
					end
				end
				psClear: state <= psTry;
				psTry: begin
					if (lastPlaced || atLimit) begin
						state <= psIdle;
						done <= 1'b1;
						// Only a complete fleet goes to the resolver.
						loadBoard <= lastPlaced;
					end
				end
				default: state <= psIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			psIdle: begin
				if (start) begin
					// A zero seed would lock the LFSR up.
					lfsr <= (cmd.seed == 8'h00) ? 8'h01 : cmd.seed;
					curShip <= cmd.shipCount;
					attempts <= 8'd0;
				end
			end
			psClear: newBoard <= '0;
			psTry: begin
				newBoard <= boardNext;
				lfsr <= lfsrNext;
				attempts <= attemptsNext;
				if (fits) begin
					curShip <= curShip - 3'd1;
				end
				if (lastPlaced || atLimit) begin
					rsp.ok <= lastPlaced;
					rsp.attempts <= attemptsNext;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/shotResolver.sv ====
`timescale 1ns/10ps
`default_nettype none

module shotResolver (
	input logic clk,
	input logic rstN,
	input logic start,
	input boardPkg::shotCmdT cmd,
	input logic loadBoard,
	input boardPkg::boardT newBoard,
	output logic done,
	output boardPkg::shotRspT rsp
);

	import boardPkg::*;
	import fleetPkg::*;

	boardT board;
	boardT boardNext;
	logic [maxShips:1][2:0] hitCount;
	logic [maxShips:1][2:0] countNext;
	logic [maxShips:1] present;
	logic [maxShips:1] loadPresent;
	logic [4:0] shotIdx;
	cellT shotCell;
	shotRspT rspNext;

	// Ships that appear on an incoming board.
	always_comb begin
		loadPresent = '0;
		for (int i = 0; i < gridSize * gridSize; i++) begin
			if (newBoard[i].shipId != 3'd0) begin
				loadPresent[newBoard[i].shipId] = 1'b1;
			end
		end
	end

	always_comb begin
		shotIdx = 5'(cmd.row) * 5'(gridSize) + 5'(cmd.col);
		shotCell = board[shotIdx];
		boardNext = board;
		countNext = hitCount;
		rspNext.shipId = shotCell.shipId;
		if (shotCell.hit) begin
			rspNext.outcome = outRepeat;
		end else if (shotCell.shipId == 3'd0) begin
			rspNext.outcome = outMiss;
			boardNext[shotIdx].hit = 1'b1;
		end else begin
			boardNext[shotIdx].hit = 1'b1;
			countNext[shotCell.shipId] = hitCount[shotCell.shipId] + 3'd1;
			// Ship k takes k hits to sink.
			rspNext.outcome = (countNext[shotCell.shipId] == shotCell.shipId) ? outSunk : outHit;
		end
		rspNext.fleetSunk = 1'b1;
		for (int k = 1; k <= maxShips; k++) begin
			if (present[k] && countNext[k] != 3'(k)) begin
				rspNext.fleetSunk = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			board <= '0;
			hitCount <= '0;
			present <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (loadBoard) begin
				board <= newBoard;
				hitCount <= '0;
				present <= loadPresent;
			end else if (start) begin
				board <= boardNext;
				hitCount <= countNext;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !loadBoard) begin
			rsp <= rspNext;
		end
	end

endmodule

`default_nettype wire

// ==== source/battleGrid.sv ====
`timescale 1ns/10ps
`default_nettype none

module battleGrid (
	input logic clk,
	input logic rstN,
	input logic placeReq,
	input fleetPkg::placeCmdT placeCmd,
	output logic placeAck,
	output fleetPkg::placeRspT placeRsp,
	input logic shotReq,
	input boardPkg::shotCmdT shotCmd,
	output logic shotAck,
	output boardPkg::shotRspT shotRsp
);

	import boardPkg::*;
	import fleetPkg::*;

	logic placeStart;
	logic placeDone;
	placeCmdT placeCmdQ;
	placeRspT placeResult;
	logic shotStart;
	logic shotDone;
	shotCmdT shotCmdQ;
	shotRspT shotResult;
	logic loadBoard;
	boardT newBoard;

	reqAckTarget #(
		.payloadT(placeCmdT),
		.resultT(placeRspT)
	) i_placeTarget (
		.clk(clk),
		.rstN(rstN),
		.req(placeReq),
		.payload(placeCmd),
		.done(placeDone),
		.result(placeResult),
		.ack(placeAck),
		.start(placeStart),
		.cmd(placeCmdQ),
		.rsp(placeRsp)
	);

	reqAckTarget #(
		.payloadT(shotCmdT),
		.resultT(shotRspT)
	) i_shotTarget (
		.clk(clk),
		.rstN(rstN),
		.req(shotReq),
		.payload(shotCmd),
		.done(shotDone),
		.result(shotResult),
		.ack(shotAck),
		.start(shotStart),
		.cmd(shotCmdQ),
		.rsp(shotRsp)
	);

	shipPlacer i_placer (
		.clk(clk),
		.rstN(rstN),
		.start(placeStart),
		.cmd(placeCmdQ),
		.done(placeDone),
		.rsp(placeResult),
		.loadBoard(loadBoard),
		.newBoard(newBoard)
	);

	shotResolver i_resolver (
		.clk(clk),
		.rstN(rstN),
		.start(shotStart),
		.cmd(shotCmdQ),
		.loadBoard(loadBoard),
		.newBoard(newBoard),
		.done(shotDone),
		.rsp(shotResult)
	);

endmodule

`default_nettype wire

// ==== verif/tbChecks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Mismatch counts, one per kind of response.
int placeErrors = 0;
int shotErrors = 0;

task automatic checkPlace(input placeRspT got, input placeRspT exp, input placeCmdT cmd);
	if (got !== exp) begin
		placeErrors++;
		$display("[ERROR] placeRsp = %h, expected %h (ok %h/%h, attempts %h/%h, seed %h)",
			got, exp, got.ok, exp.ok, got.attempts, exp.attempts, cmd.seed);
	end
endtask

task automatic checkShot(input shotRspT got, input shotRspT exp, input shotCmdT cmd);
	if (got !== exp) begin
		shotErrors++;
		$display("[ERROR] shotRsp = %h, expected %h (outcome %h/%h, shipId %h/%h, fleetSunk %h/%h)",
			got, exp, got.outcome, exp.outcome, got.shipId, exp.shipId,
			got.fleetSunk, exp.fleetSunk);
		$display("        at row %h col %h", cmd.row, cmd.col);
	end
endtask

`endif

// ==== verif/tbBattleGrid.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbBattleGrid;

	import boardPkg::*;
	import fleetPkg::*;

	localparam int cells = gridSize * gridSize;
	localparam int numPlacements = 10;
	localparam int randomShots = 8;
	localparam int repeatShots = 5;
	// Longest ship, random shots, one repeat, full sweep, then repeats.
	localparam int shotsPerPlace = maxShips + randomShots + 1 + cells + repeatShots;
	localparam int timeoutLimit = numPlacements * 270 + numPlacements * shotsPerPlace * 10;

	logic clk;
	logic rstN;
	logic placeReq;
	placeCmdT placeCmd;
	logic placeAck;
	placeRspT placeRsp;
	logic shotReq;
	shotCmdT shotCmd;
	logic shotAck;
	shotRspT shotRsp;
	integer seed;
	int cycles = 0;

	// Model of the resolver's board and hit counters.
	logic [2:0] modelShip [cells];
	logic modelHit [cells];
	int modelCount [1:maxShips];
	logic modelPresent [1:maxShips];

	`include "tbChecks.svh"

	battleGrid i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeoutLimit) begin
			$display("Timeout: the DUT did not finish its handshakes in %0d cycles", timeoutLimit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Placement rule; a complete fleet replaces the model board.
	function automatic placeRspT modelPlace(input placeCmdT c);
		logic [7:0] v;
		logic [2:0] work [cells];
		int ship;
		int tries;
		int base;
		bit fits;
		bit finished;
		bit lsb;
		placeRspT r;
		v = (c.seed == 8'h00) ? 8'h01 : c.seed;
		ship = int'(c.shipCount);
		tries = 0;
		finished = 1'b0;
		r = '0;
		foreach (work[i]) work[i] = 3'd0;
		while (!finished) begin
			base = (int'(v[2:0]) % gridSize) * gridSize + int'(v[5:3]) % (gridSize + 1 - ship);
			fits = 1'b1;
			for (int i = 0; i < ship; i++) begin
				if (work[base + i] != 3'd0) fits = 1'b0;
			end
			for (int i = 0; i < ship; i++) begin
				if (fits) work[base + i] = 3'(ship);
			end
			lsb = v[0];
			v = (v >> 1) ^ (lsb ? lfsrTaps : 8'h00);
			tries++;
			if (fits && ship == 1) r.ok = 1'b1;
			finished = r.ok || tries == maxAttempts;
			if (fits) ship--;
		end
		r.attempts = 8'(tries);
		if (r.ok) begin
			foreach (modelShip[i]) modelShip[i] = work[i];
			foreach (modelHit[i]) modelHit[i] = 1'b0;
			for (int k = 1; k <= maxShips; k++) begin
				modelCount[k] = 0;
				modelPresent[k] = k <= int'(c.shipCount);
			end
		end
		return r;
	endfunction

	function automatic shotRspT modelShot(input shotCmdT c);
		int idx;
		int id;
		shotRspT r;
		idx = int'(c.row) * gridSize + int'(c.col);
		id = int'(modelShip[idx]);
		r.shipId = modelShip[idx];
		if (modelHit[idx]) begin
			r.outcome = outRepeat;
		end else begin
			modelHit[idx] = 1'b1;
			if (id != 0) modelCount[id]++;
			r.outcome = (id == 0) ? outMiss : (modelCount[id] == id) ? outSunk : outHit;
		end
		r.fleetSunk = 1'b1;
		for (int k = 1; k <= maxShips; k++) begin
			if (modelPresent[k] && modelCount[k] != k) r.fleetSunk = 1'b0;
		end
		return r;
	endfunction

	// Host side of the four-phase handshake, sampled 1 ns after each edge.
	task automatic sendPlace(input placeCmdT c, output placeRspT r);
		placeCmd = c;
		placeReq = 1'b1;
		do @(posedge clk) #1; while (!placeAck);
		r = placeRsp;
		placeReq = 1'b0;
		do @(posedge clk) #1; while (placeAck);
	endtask

	task automatic fireAt(input int row, input int col);
		shotCmdT c;
		shotRspT exp;
		shotRspT got;
		c.row = 3'(row);
		c.col = 3'(col);
		exp = modelShot(c);
		shotCmd = c;
		shotReq = 1'b1;
		do @(posedge clk) #1; while (!shotAck);
		got = shotRsp;
		shotReq = 1'b0;
		do @(posedge clk) #1; while (shotAck);
		checkShot(got, exp, c);
	endtask

	initial begin
		placeCmdT pc;
		placeRspT exp;
		placeRspT got;
		int target;
		int row;
		int col;
		seed = 32'hab5f926f;
		{placeReq, placeCmd, shotReq, shotCmd} = '0;
		rstN = 1'b0;
		foreach (modelShip[i]) {modelShip[i], modelHit[i]} = '0;
		for (int k = 1; k <= maxShips; k++) {modelCount[k], modelPresent[k]} = '0;
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		for (int p = 0; p < numPlacements; p++) begin
			// The first seed is zero, which the placer swaps for 8'h01.
			pc.seed = (p == 0) ? 8'h00 : 8'($random(seed));
			pc.shipCount = 3'(1 + randBelow(maxShips));
			exp = modelPlace(pc);
			sendPlace(pc, got);
			checkPlace(got, exp, pc);
			target = 0;
			for (int k = 1; k <= maxShips; k++) begin
				if (modelPresent[k]) begin
					target = k;
				end
			end
			// Longest ship first, so only its last cell may sink it.
			for (int i = 0; i < cells; i++) begin
				if (target != 0 && modelShip[i] == 3'(target)) begin
					fireAt(i / gridSize, i % gridSize);
				end
			end
			for (int s = 0; s < randomShots; s++) begin
				row = randBelow(gridSize);
				col = randBelow(gridSize);
				fireAt(row, col);
			end
			fireAt(row, col);
			for (int i = 0; i < cells; i++) fireAt(i / gridSize, i % gridSize);
			for (int s = 0; s < repeatShots; s++) fireAt(randBelow(gridSize), randBelow(gridSize));
		end
		$display("Errors: %0d placement, %0d shot", placeErrors, shotErrors);
		if (placeErrors + shotErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verif
source/boardPkg.sv
source/fleetPkg.sv
source/reqAckTarget.sv
source/shipPlacer.sv
source/shotResolver.sv
source/battleGrid.sv
verif/tbBattleGrid.sv

// ==== run.sh ====
#!/bin/bash
# Builds and runs the testbench with Verilator, then scans the log for failure.
cd "$(dirname "$0")" || exit 1
set -o pipefail
verilator --binary --timing -Wno-fatal -f tb.f --top-module tbBattleGrid \
	-Mdir obj_dir -o simBattleGrid \
	&& ./obj_dir/simBattleGrid 2>&1 | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
